//--- logic/ahb_pkg.sv
package ahb_pkg;

	// ------------------------------
	// Bus widths
	// ------------------------------
	localparam int addr_width = 32;
	localparam int data_width = 32;

	// ------------------------------
	// HTRANS, bit 1 marks an active transfer
	// ------------------------------
	localparam logic [1:0] htrans_idle   = 2'b00;
	localparam logic [1:0] htrans_busy   = 2'b01; // No burst master here
	localparam logic [1:0] htrans_nonseq = 2'b10;
	localparam logic [1:0] htrans_seq    = 2'b11;

	localparam logic [2:0] hsize_byte = 3'b000;
	localparam logic [2:0] hsize_half = 3'b001;
	localparam logic [2:0] hsize_word = 3'b010;

	localparam logic hresp_okay  = 1'b0;
	localparam logic hresp_error = 1'b1;

	// Little-endian byte lanes touched by one transfer
	function automatic logic [3:0] byte_lanes(input logic [2:0] size, input logic [1:0] addr);
		case (size)
			hsize_byte: byte_lanes = 4'b0001 << addr;
			hsize_half: byte_lanes = addr[1] ? 4'b1100 : 4'b0011;
			default:    byte_lanes = 4'b1111;
		endcase
	endfunction

endpackage

//--- logic/soc_map_pkg.sv
package soc_map_pkg;

	// ------------------------------
	// Memory map
	// ------------------------------
	localparam logic [31:0] sram_base    = 32'h2000_0000;
	localparam int          sram_aw      = 12; // 4 KB, 1024 words
	localparam logic [31:0] gpio_base    = 32'h4001_0000;
	localparam int          gpio_aw      = 12;
	localparam int          region_shift = 16; // Bits below this are ignored by the decode

	// ------------------------------
	// GPIO block
	// ------------------------------
	localparam int gpio_width = 16;

	localparam logic [gpio_aw-1:0] gpio_data_ofs    = 12'h000; // Synchronized pins
	localparam logic [gpio_aw-1:0] gpio_dout_ofs    = 12'h004;
	localparam logic [gpio_aw-1:0] gpio_oe_ofs      = 12'h008;
	localparam logic [gpio_aw-1:0] gpio_inten_ofs   = 12'h00C;
	localparam logic [gpio_aw-1:0] gpio_intstat_ofs = 12'h010; // Write one to clear

endpackage

//--- logic/ahb_decoder.sv
module ahb_decoder (
	input  logic                           hclk_i,
	input  logic                           rst_n_i,
	input  logic [ahb_pkg::addr_width-1:0] haddr_i,
	input  logic [1:0]                     htrans_i,
	input  logic [ahb_pkg::data_width-1:0] hrdata_sram_i,
	input  logic                           hready_sram_i,
	input  logic                           hresp_sram_i,
	input  logic [ahb_pkg::data_width-1:0] hrdata_gpio_i,
	input  logic                           hready_gpio_i,
	input  logic                           hresp_gpio_i,
	output logic                           hsel_sram_o,
	output logic                           hsel_gpio_o,
	output logic                           hready_o,
	output logic                           hresp_o,
	output logic [ahb_pkg::data_width-1:0] hrdata_o
);

	typedef enum logic [1:0] {def_idle, def_err1, def_err2} def_state_t;

	def_state_t def_state_q;  // Default slave
	logic       dsel_sram_q;  // Data-phase owner
	logic       dsel_gpio_q;
	logic       unmapped;
	logic       def_ready;
	logic       def_resp;

	// ------------------------------
	// Address phase decode
	// ------------------------------
	assign hsel_sram_o = (haddr_i >> soc_map_pkg::region_shift) ==
		(soc_map_pkg::sram_base >> soc_map_pkg::region_shift);
	assign hsel_gpio_o = (haddr_i >> soc_map_pkg::region_shift) ==
		(soc_map_pkg::gpio_base >> soc_map_pkg::region_shift);
	assign unmapped    = !hsel_sram_o && !hsel_gpio_o;

	always_ff @(posedge hclk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			dsel_sram_q <= 1'b0;
			dsel_gpio_q <= 1'b0;
		end else if (hready_o) begin // Advance only when the bus moves
			dsel_sram_q <= hsel_sram_o;
			dsel_gpio_q <= hsel_gpio_o;
		end
	end

	// Two-cycle ERROR for active transfers nobody claims
	always_ff @(posedge hclk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			def_state_q <= def_idle;
		end else begin
			case (def_state_q)
				def_err1: def_state_q <= def_err2;
				default: begin
					if (hready_o && htrans_i[1] && unmapped)
						def_state_q <= def_err1;
					else
						def_state_q <= def_idle;
				end
			endcase
		end
	end

	assign def_ready = (def_state_q != def_err1);
	assign def_resp  = (def_state_q == def_idle) ? ahb_pkg::hresp_okay : ahb_pkg::hresp_error;

	// ------------------------------
	// Data phase multiplexing
	// ------------------------------
	always_comb begin
		if (dsel_sram_q) begin
			hrdata_o = hrdata_sram_i;
			hready_o = hready_sram_i;
			hresp_o  = hresp_sram_i;
		end else if (dsel_gpio_q) begin
			hrdata_o = hrdata_gpio_i;
			hready_o = hready_gpio_i;
			hresp_o  = hresp_gpio_i;
		end else begin
			hrdata_o = '0;
			hready_o = def_ready;
			hresp_o  = def_resp;
		end
	end

	a_sel_onehot: assert property (@(posedge hclk_i) disable iff (!rst_n_i)
		$onehot0({hsel_sram_o, hsel_gpio_o}))
		else $error("Overlapping slave regions in the memory map");

	// Master must go idle while the error response stalls the bus
	a_idle_in_stall: assert property (@(posedge hclk_i) disable iff (!rst_n_i)
		!hready_o |-> htrans_i == ahb_pkg::htrans_idle)
		else $error("Active transfer issued during an error stall");

endmodule

//--- logic/ahb_sram.sv
module ahb_sram (
	input  logic                           hclk_i,
	input  logic                           rst_n_i,
	input  logic                           hsel_i,
	input  logic                           hready_i,
	input  logic [soc_map_pkg::sram_aw-1:0] haddr_i,
	input  logic [1:0]                     htrans_i,
	input  logic                           hwrite_i,
	input  logic [2:0]                     hsize_i,
	input  logic [ahb_pkg::data_width-1:0] hwdata_i,
	output logic                           hreadyout_o,
	output logic                           hresp_o,
	output logic [ahb_pkg::data_width-1:0] hrdata_o
);

	logic [ahb_pkg::data_width-1:0]  mem [0:(1 << (soc_map_pkg::sram_aw - 2)) - 1];
	logic                            trans_valid;
	logic                            wr_en_q;   // Write pending in data phase
	logic [soc_map_pkg::sram_aw-3:0] wr_addr_q; // Word index
	logic [3:0]                      wr_mask_q;
	logic [ahb_pkg::data_width-1:0]  wr_word;
	logic [ahb_pkg::data_width-1:0]  rd_data_q;

	assign trans_valid = hsel_i && hready_i && htrans_i[1];

	// ------------------------------
	// Write merge
	// ------------------------------
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			wr_word[8*i +: 8] = wr_mask_q[i] ? hwdata_i[8*i +: 8] : mem[wr_addr_q][8*i +: 8];
		end
	end

	always_ff @(posedge hclk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			wr_en_q <= 1'b0;
		else
			wr_en_q <= trans_valid && hwrite_i;
	end

	always_ff @(posedge hclk_i) begin
		if (trans_valid) begin
			wr_addr_q <= haddr_i[soc_map_pkg::sram_aw-1:2];
			wr_mask_q <= ahb_pkg::byte_lanes(hsize_i, haddr_i[1:0]);
		end
		if (wr_en_q)
			mem[wr_addr_q] <= wr_word;
	end

	// ------------------------------
	// Read with write forwarding
	// ------------------------------
	always_ff @(posedge hclk_i) begin
		if (trans_valid && !hwrite_i) begin
			if (wr_en_q && wr_addr_q == haddr_i[soc_map_pkg::sram_aw-1:2])
				rd_data_q <= wr_word; // Array not updated yet
			else
				rd_data_q <= mem[haddr_i[soc_map_pkg::sram_aw-1:2]];
		end
	end

	assign hrdata_o    = rd_data_q;
	assign hreadyout_o = 1'b1;               // Zero wait states
	assign hresp_o     = ahb_pkg::hresp_okay;

	a_aligned: assert property (@(posedge hclk_i) disable iff (!rst_n_i)
		trans_valid |-> (hsize_i == ahb_pkg::hsize_byte) ||
			(hsize_i == ahb_pkg::hsize_half && !haddr_i[0]) ||
			(hsize_i == ahb_pkg::hsize_word && haddr_i[1:0] == 2'b00))
		else $error("Unaligned or oversized SRAM transfer");

endmodule

//--- logic/ahb_gpio.sv
module ahb_gpio (
	input  logic                               hclk_i,
	input  logic                               rst_n_i,
	input  logic                               hsel_i,
	input  logic                               hready_i,
	input  logic [soc_map_pkg::gpio_aw-1:0]    haddr_i,
	input  logic [1:0]                         htrans_i,
	input  logic                               hwrite_i,
	input  logic [2:0]                         hsize_i,
	input  logic [ahb_pkg::data_width-1:0]     hwdata_i,
	input  logic [soc_map_pkg::gpio_width-1:0] gpio_in_i,
	output logic                               hreadyout_o,
	output logic                               hresp_o,
	output logic [ahb_pkg::data_width-1:0]     hrdata_o,
	output logic [soc_map_pkg::gpio_width-1:0] gpio_out_o,
	output logic [soc_map_pkg::gpio_width-1:0] gpio_oe_o,
	output logic [soc_map_pkg::gpio_width-1:0] gpio_int_o,
	output logic                               gpio_comb_int_o
);

	logic                               trans_valid;
	logic                               wr_en_q;
	logic [soc_map_pkg::gpio_aw-1:0]    addr_q;  // Word-aligned offset
	logic [3:0]                         lanes_q;
	logic [soc_map_pkg::gpio_width-1:0] wr_mask; // Per-bit write enable
	logic [soc_map_pkg::gpio_width-1:0] wr_data;
	logic [soc_map_pkg::gpio_width-1:0] meta_q;  // First sync stage
	logic [soc_map_pkg::gpio_width-1:0] sync_q;  // Data register value
	logic [soc_map_pkg::gpio_width-1:0] dout_q;
	logic [soc_map_pkg::gpio_width-1:0] oe_q;
	logic [soc_map_pkg::gpio_width-1:0] inten_q;
	logic [soc_map_pkg::gpio_width-1:0] intstat_q;
	logic [soc_map_pkg::gpio_width-1:0] rise;
	logic [soc_map_pkg::gpio_width-1:0] int_clear;
	logic [soc_map_pkg::gpio_width-1:0] rd_val;

	assign trans_valid = hsel_i && hready_i && htrans_i[1];

	always_ff @(posedge hclk_i) begin
		if (trans_valid) begin
			addr_q  <= {haddr_i[soc_map_pkg::gpio_aw-1:2], 2'b00};
			lanes_q <= ahb_pkg::byte_lanes(hsize_i, haddr_i[1:0]);
		end
	end

	always_comb begin
		for (int i = 0; i < soc_map_pkg::gpio_width; i++) begin
			wr_mask[i] = lanes_q[i / 8];
		end
	end

	assign wr_data   = hwdata_i[soc_map_pkg::gpio_width-1:0];
	assign rise      = meta_q & ~sync_q; // New level against the held one
	assign int_clear = (wr_en_q && addr_q == soc_map_pkg::gpio_intstat_ofs) ?
		(wr_data & wr_mask) : '0;

	// ------------------------------
	// Registers and synchronizer
	// ------------------------------
	always_ff @(posedge hclk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_en_q   <= 1'b0;
			meta_q    <= '0;
			sync_q    <= '0;
			dout_q    <= '0;
			oe_q      <= '0;
			inten_q   <= '0;
			intstat_q <= '0;
		end else begin
			wr_en_q <= trans_valid && hwrite_i;
			meta_q  <= gpio_in_i;
			sync_q  <= meta_q;
			if (wr_en_q && addr_q == soc_map_pkg::gpio_dout_ofs)
				dout_q <= (dout_q & ~wr_mask) | (wr_data & wr_mask);
			if (wr_en_q && addr_q == soc_map_pkg::gpio_oe_ofs)
				oe_q <= (oe_q & ~wr_mask) | (wr_data & wr_mask);
			if (wr_en_q && addr_q == soc_map_pkg::gpio_inten_ofs)
				inten_q <= (inten_q & ~wr_mask) | (wr_data & wr_mask);
			intstat_q <= (intstat_q & ~int_clear) | (rise & inten_q); // Set wins
		end
	end

	always_comb begin
		case (addr_q)
			soc_map_pkg::gpio_data_ofs:    rd_val = sync_q;
			soc_map_pkg::gpio_dout_ofs:    rd_val = dout_q;
			soc_map_pkg::gpio_oe_ofs:      rd_val = oe_q;
			soc_map_pkg::gpio_inten_ofs:   rd_val = inten_q;
			soc_map_pkg::gpio_intstat_ofs: rd_val = intstat_q;
			default:                       rd_val = '0;
		endcase
	end

	assign hrdata_o        = {{(ahb_pkg::data_width - soc_map_pkg::gpio_width){1'b0}}, rd_val};
	assign hreadyout_o     = 1'b1;
	assign hresp_o         = ahb_pkg::hresp_okay;
	assign gpio_out_o      = dout_q;
	assign gpio_oe_o       = oe_q;
	assign gpio_int_o      = intstat_q;
	assign gpio_comb_int_o = |intstat_q;

endmodule

//--- logic/soc_top.sv
module soc_top (
	input  logic                               hclk_i,
	input  logic                               rst_n_i,
	input  logic [ahb_pkg::addr_width-1:0]     haddr_i,
	input  logic [1:0]                         htrans_i,
	input  logic                               hwrite_i,
	input  logic [2:0]                         hsize_i,
	input  logic [ahb_pkg::data_width-1:0]     hwdata_i,
	input  logic [soc_map_pkg::gpio_width-1:0] gpio_in_i,
	output logic [ahb_pkg::data_width-1:0]     hrdata_o,
	output logic                               hready_o,
	output logic                               hresp_o,
	output logic [soc_map_pkg::gpio_width-1:0] gpio_out_o,
	output logic [soc_map_pkg::gpio_width-1:0] gpio_oe_o,
	output logic [soc_map_pkg::gpio_width-1:0] gpio_int_o,
	output logic                               gpio_comb_int_o
);

	logic                           hsel_sram;
	logic                           hsel_gpio;
	logic [ahb_pkg::data_width-1:0] hrdata_sram;
	logic                           hready_sram;
	logic                           hresp_sram;
	logic [ahb_pkg::data_width-1:0] hrdata_gpio;
	logic                           hready_gpio;
	logic                           hresp_gpio;

	// ------------------------------
	// Bus fabric
	// ------------------------------
	ahb_decoder decoder_instance (
		.hclk_i        (hclk_i),
		.rst_n_i       (rst_n_i),
		.haddr_i       (haddr_i),
		.htrans_i      (htrans_i),
		.hrdata_sram_i (hrdata_sram),
		.hready_sram_i (hready_sram),
		.hresp_sram_i  (hresp_sram),
		.hrdata_gpio_i (hrdata_gpio),
		.hready_gpio_i (hready_gpio),
		.hresp_gpio_i  (hresp_gpio),
		.hsel_sram_o   (hsel_sram),
		.hsel_gpio_o   (hsel_gpio),
		.hready_o      (hready_o),     // Also the global HREADY for slaves
		.hresp_o       (hresp_o),
		.hrdata_o      (hrdata_o)
	);

	ahb_sram sram_instance (
		.hclk_i      (hclk_i),
		.rst_n_i     (rst_n_i),
		.hsel_i      (hsel_sram),
		.hready_i    (hready_o),
		.haddr_i     (haddr_i[soc_map_pkg::sram_aw-1:0]),
		.htrans_i    (htrans_i),
		.hwrite_i    (hwrite_i),
		.hsize_i     (hsize_i),
		.hwdata_i    (hwdata_i),
		.hreadyout_o (hready_sram),
		.hresp_o     (hresp_sram),
		.hrdata_o    (hrdata_sram)
	);

	ahb_gpio gpio_instance (
		.hclk_i          (hclk_i),
		.rst_n_i         (rst_n_i),
		.hsel_i          (hsel_gpio),
		.hready_i        (hready_o),
		.haddr_i         (haddr_i[soc_map_pkg::gpio_aw-1:0]),
		.htrans_i        (htrans_i),
		.hwrite_i        (hwrite_i),
		.hsize_i         (hsize_i),
		.hwdata_i        (hwdata_i),
		.gpio_in_i       (gpio_in_i),
		.hreadyout_o     (hready_gpio),
		.hresp_o         (hresp_gpio),
		.hrdata_o        (hrdata_gpio),
		.gpio_out_o      (gpio_out_o),
		.gpio_oe_o       (gpio_oe_o),
		.gpio_int_o      (gpio_int_o),
		.gpio_comb_int_o (gpio_comb_int_o)
	);

endmodule

//--- verification/soc_top_tb.sv
module soc_top_tb;

	timeunit 1ns;
	timeprecision 1ps;

	typedef enum {k_wr, k_rd, k_idle, k_pin, k_err, k_out, k_int} kind_t;

	localparam int max_steps = 64;
	localparam logic [31:0] sram = 32'h2000_0000;
	localparam logic [31:0] gpio = 32'h4001_0000;

	logic        hclk_i;
	logic        rst_n_i;
	logic [31:0] haddr_i;
	logic [1:0]  htrans_i;
	logic        hwrite_i;
	logic [2:0]  hsize_i;
	logic [31:0] hwdata_i;
	logic [15:0] gpio_in_i;
	logic [31:0] hrdata_o;
	logic        hready_o;
	logic        hresp_o;
	logic [15:0] gpio_out_o;
	logic [15:0] gpio_oe_o;
	logic [15:0] gpio_int_o;
	logic        gpio_comb_int_o;

	kind_t       kind_tab [max_steps];
	logic [31:0] addr_tab [max_steps];
	logic [2:0]  size_tab [max_steps];
	logic [31:0] data_tab [max_steps];
	logic [31:0] exp_tab  [max_steps];
	logic [31:0] shadow   [1024]; // SRAM reference model
	int          n_steps;
	int          cycles;
	int          limit;
	logic [31:0] rnd;

	soc_top UUT (.*);

	// ------------------------------
	// Clock and timeout
	// ------------------------------
	initial begin
		hclk_i = 1'b0;
		forever #50 hclk_i = ~hclk_i;
	end

	initial begin
		cycles = 0;
		forever begin
			@(posedge hclk_i);
			cycles++;
			if (limit > 0 && cycles > limit)
				report_failure("Simulation ran past its cycle limit");
		end
	end

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("mismatch %s expected %h got %h", name, exp, got);
			report_failure("Value check failed");
		end
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// ------------------------------
	// Table construction
	// ------------------------------
	task automatic add(input kind_t k, input logic [31:0] a, input logic [2:0] sz,
			input logic [31:0] d, input logic [31:0] e);
		kind_tab[n_steps] = k;
		addr_tab[n_steps] = a;
		size_tab[n_steps] = sz;
		data_tab[n_steps] = d;
		exp_tab[n_steps]  = e;
		n_steps++;
	endtask

	// Little-endian lanes: bytes from the aligned start up to the size
	task automatic add_sram_wr(input logic [11:0] ofs, input logic [2:0] sz);
		int nbytes;
		int first;
		nbytes = 1 << sz;
		first  = int'(ofs[1:0]) & ~(nbytes - 1);
		rnd = xorshift(rnd);
		for (int b = first; b < first + nbytes; b++)
			shadow[ofs[11:2]][8*b +: 8] = rnd[8*b +: 8];
		add(k_wr, sram + 32'(ofs), sz, rnd, 32'h0);
	endtask

	task automatic add_sram_rd(input logic [11:0] ofs);
		add(k_rd, sram + 32'(ofs), 3'd2, 32'h0, shadow[ofs[11:2]]);
	endtask

	task automatic build_table();
		n_steps = 0;
		rnd = 32'h2b193aa7;
		add_sram_wr(12'h000, 3'd2);  // Back-to-back words
		add_sram_wr(12'h004, 3'd2);
		add_sram_rd(12'h004);
		add_sram_rd(12'h000);
		add_sram_wr(12'h010, 3'd2);
		add_sram_wr(12'hFFC, 3'd2);
		add_sram_rd(12'h010);
		add_sram_rd(12'hFFC);
		add_sram_wr(12'h001, 3'd0);  // Sub-word lanes
		add_sram_wr(12'h003, 3'd0);
		add_sram_rd(12'h000);
		add_sram_wr(12'h006, 3'd1);
		add_sram_rd(12'h004);
		add_sram_wr(12'h010, 3'd1);
		add_sram_wr(12'h012, 3'd0);
		add_sram_rd(12'h010);
		add(k_wr, gpio + 32'h4, 3'd2, 32'h0000_A5C3, 32'h0);
		add(k_wr, gpio + 32'h8, 3'd2, 32'h0000_00FF, 32'h0);
		add(k_idle, 32'h0, 3'd2, 32'h0, 32'h0);
		add(k_out, 32'h0, 3'd2, 32'h0000_A5C3, 32'h0000_00FF);
		add(k_pin, 32'h0, 3'd2, 32'h0000_1234, 32'h0);
		add(k_idle, 32'h0, 3'd2, 32'h0, 32'h0);
		add(k_rd, gpio, 3'd2, 32'h0, 32'h0000_1234);
		add(k_wr, gpio + 32'hC, 3'd2, 32'h0000_0003, 32'h0);
		add(k_pin, 32'h0, 3'd2, 32'h0000_1235, 32'h0); // Pin 0 rises, enabled
		add(k_idle, 32'h0, 3'd2, 32'h0, 32'h0);
		add(k_idle, 32'h0, 3'd2, 32'h0, 32'h0);
		add(k_int, 32'h0, 3'd2, 32'h0, 32'h0000_0001);
		add(k_pin, 32'h0, 3'd2, 32'h0000_1275, 32'h0); // Pin 6 rises, disabled
		add(k_idle, 32'h0, 3'd2, 32'h0, 32'h0);
		add(k_idle, 32'h0, 3'd2, 32'h0, 32'h0);
		add(k_int, 32'h0, 3'd2, 32'h0, 32'h0000_0001);
		add(k_rd, gpio + 32'h10, 3'd2, 32'h0, 32'h0000_0001);
		add(k_wr, gpio + 32'h10, 3'd2, 32'h0000_0001, 32'h0);
		add(k_idle, 32'h0, 3'd2, 32'h0, 32'h0);
		add(k_int, 32'h0, 3'd2, 32'h0, 32'h0000_0000);
		add(k_err, 32'h3000_0000, 3'd2, 32'h0, 32'h0);
		add_sram_rd(12'h004);
	endtask

	// ------------------------------
	// Main sequence
	// ------------------------------
	initial begin
		kind_t       pend_kind;
		logic [31:0] pend_data;
		logic [31:0] pend_exp;
		kind_t       k;
		limit     = 0;
		rst_n_i   = 1'b0;
		haddr_i   = '0;
		htrans_i  = 2'b00;
		hwrite_i  = 1'b0;
		hsize_i   = 3'd2;
		hwdata_i  = '0;
		gpio_in_i = '0;
		build_table();
		limit = 16 + 4 * n_steps + 50;
		repeat (16) @(posedge hclk_i);
		#5 rst_n_i = 1'b1;
		@(negedge hclk_i);
		check_value("hready_o", 32'(hready_o), 32'h1);
		check_value("hresp_o", 32'(hresp_o), 32'h0);
		check_value("gpio_out_o", 32'(gpio_out_o), 32'h0);
		check_value("gpio_oe_o", 32'(gpio_oe_o), 32'h0);
		check_value("gpio_int_o", 32'(gpio_int_o), 32'h0);
		check_value("gpio_comb_int_o", 32'(gpio_comb_int_o), 32'h0);
		pend_kind = k_idle;
		pend_data = '0;
		pend_exp  = '0;
		for (int i = 0; i <= n_steps; i++) begin
			k = (i == n_steps) ? k_idle : kind_tab[i];
			@(posedge hclk_i);
			#5;
			haddr_i  = (i == n_steps) ? 32'h0 : addr_tab[i];
			hsize_i  = (i == n_steps) ? 3'd2 : size_tab[i];
			htrans_i = (k == k_wr || k == k_rd || k == k_err) ? 2'b10 : 2'b00;
			hwrite_i = (k == k_wr);
			hwdata_i = (pend_kind == k_wr) ? pend_data : 32'h0;
			if (k == k_pin)
				gpio_in_i = data_tab[i][15:0];
			@(negedge hclk_i);
			if (pend_kind == k_err) begin
				check_value("hready_o", 32'(hready_o), 32'h1);
				check_value("hresp_o", 32'(hresp_o), 32'h1);
			end else begin
				check_value("hready_o", 32'(hready_o), 32'h1);
				check_value("hresp_o", 32'(hresp_o), 32'h0);
				if (pend_kind == k_rd)
					check_value("hrdata_o", hrdata_o, pend_exp);
			end
			if (k == k_out) begin
				check_value("gpio_out_o", 32'(gpio_out_o), data_tab[i] & 32'hFFFF);
				check_value("gpio_oe_o", 32'(gpio_oe_o), exp_tab[i]);
			end
			if (k == k_int) begin
				check_value("gpio_int_o", 32'(gpio_int_o), exp_tab[i]);
				check_value("gpio_comb_int_o", 32'(gpio_comb_int_o), 32'(exp_tab[i] != 0));
			end
			if (k == k_err) begin // First error cycle stalls the bus
				@(posedge hclk_i);
				#5;
				htrans_i = 2'b00;
				hwrite_i = 1'b0;
				hwdata_i = '0;
				@(negedge hclk_i);
				check_value("hready_o", 32'(hready_o), 32'h0);
				check_value("hresp_o", 32'(hresp_o), 32'h1);
			end
			pend_kind = k;
			pend_data = (i == n_steps) ? 32'h0 : data_tab[i];
			pend_exp  = (i == n_steps) ? 32'h0 : exp_tab[i];
		end
		$display("All checks passed");
		$finish;
	end

endmodule

//--- soc_top.f
logic/ahb_pkg.sv
logic/soc_map_pkg.sv
logic/ahb_decoder.sv
logic/ahb_sram.sv
logic/ahb_gpio.sv
logic/soc_top.sv
verification/soc_top_tb.sv

//--- Makefile
SRCS := $(shell cat soc_top.f)

.PHONY: all run clean

all: obj_dir/Vsoc_top_tb

obj_dir/Vsoc_top_tb: soc_top.f $(SRCS)
	verilator --binary --timing --assert --top-module soc_top_tb \
		-f soc_top.f -o Vsoc_top_tb

run: obj_dir/Vsoc_top_tb
	@out="$$(./obj_dir/Vsoc_top_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir
